/* run_sim.sh */
#!/usr/bin/env bash

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "Cannot enter the project directory"
    exit 1
fi

verilator --binary --timing --assert -f rv64_min.f --top-module rv64_min_tb -o rv64_min_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_output="$(./obj_dir/rv64_min_sim)"
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

# Verdict comes from the testbench's own message
if echo "$sim_output" | grep -qx "Regression passed"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

/* rv64_core.sv */
`timescale 1ns/100ps
`default_nettype none

module rv64_core (
    input  logic                 clk,
    input  logic                 reset,             // Active low
    input  rv64_isa_pkg::iword_t instruction,       // Combinational from pc
    input  logic [3:0]           interrupt_vector,
    input  rv64_isa_pkg::xword_t bus_read_data,
    output rv64_isa_pkg::xword_t pc,
    output logic                 heartbeat,
    output logic                 interrupt_ack,
    output rv64_isa_pkg::xword_t bus_address,
    output rv64_isa_pkg::xword_t bus_write_data,
    output logic                 bus_write_enable,
    output logic                 bus_read_enable
);
    import rv64_isa_pkg::*;

    // Decode to execute
    op_e      op;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    xword_t   imm;

    // Register file ports
    xword_t   rs1_data;
    xword_t   rs2_data;
    logic     rd_write;
    reg_idx_t rd_index;
    xword_t   rd_data;

    rv64_decode u_decode (
        .clk         (clk),
        .reset       (reset),
        .instruction (instruction),
        .heartbeat   (heartbeat),
        .op          (op),
        .rd          (rd),
        .rs1         (rs1),
        .rs2         (rs2),
        .imm         (imm)
    );

    rv64_execute u_execute (
        .clk              (clk),
        .reset            (reset),
        .op               (op),
        .rd               (rd),
        .imm              (imm),
        .rs1_data         (rs1_data),
        .rs2_data         (rs2_data),
        .interrupt_vector (interrupt_vector),
        .bus_read_data    (bus_read_data),
        .pc               (pc),
        .interrupt_ack    (interrupt_ack),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_write_enable (bus_write_enable),
        .bus_read_enable  (bus_read_enable),
        .rd_write         (rd_write),
        .rd_index         (rd_index),
        .rd_data          (rd_data)
    );

    rv64_result u_result (
        .clk      (clk),
        .reset    (reset),
        .rd_write (rd_write),
        .rd_index (rd_index),
        .rd_data  (rd_data),
        .rs1      (rs1),
        .rs2      (rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

endmodule

`default_nettype wire

/* rv64_csr_pkg.sv */
`default_nettype none

package rv64_csr_pkg;

    typedef logic [11:0] csr_addr_t;

    // Machine CSR addresses, only the ones trap entry and MRET touch
    localparam csr_addr_t CSR_MSTATUS = 12'h300;
    localparam csr_addr_t CSR_MTVEC   = 12'h305;
    localparam csr_addr_t CSR_MEPC    = 12'h341;
    localparam csr_addr_t CSR_MCAUSE  = 12'h342;

    // mstatus fields
    localparam int unsigned MSTATUS_MIE  = 3;  // Global M-mode interrupt enable
    localparam int unsigned MSTATUS_MPIE = 7;  // MIE before the trap

    // mcause encoding
    // Top bit marks an interrupt, low bits hold the code
    localparam logic [63:0] CAUSE_M_EXT_INT = {1'b1, 59'd0, 4'd11};

endpackage

`default_nettype wire

/* rv64_decode.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rv64_min_cfg.svh"

module rv64_decode (
    input  logic                   clk,
    input  logic                   reset,
    input  rv64_isa_pkg::iword_t   instruction,  // Word at pc, from outside
    output logic                   heartbeat,
    output rv64_isa_pkg::op_e      op,
    output rv64_isa_pkg::reg_idx_t rd,
    output rv64_isa_pkg::reg_idx_t rs1,
    output rv64_isa_pkg::reg_idx_t rs2,
    output rv64_isa_pkg::xword_t   imm
);
    import rv64_isa_pkg::*;

    iword_t  ir;      // Instruction register
    opcode_t opcode;
    funct3_t funct3;
    xword_t  imm_u;
    xword_t  imm_i;
    xword_t  imm_s;

    // Fetch stage, loads every cycle, no stall path
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            ir        <= `IR_RESET;
            heartbeat <= 1'b0;
        end else begin
            ir        <= instruction;
            heartbeat <= ~heartbeat;  // Alive indicator
        end
    end

    // Fixed fields
    assign opcode = ir[6:0];
    assign funct3 = ir[F3_LSB +: 3];
    assign rd     = ir[RD_LSB +: 5];
    assign rs1    = ir[RS1_LSB +: 5];
    assign rs2    = ir[RS2_LSB +: 5];

    // Sign-extended immediates
    assign imm_u = {{32{ir[31]}}, ir[31:12], 12'b0};        // LUI, already shifted
    assign imm_i = {{52{ir[31]}}, ir[31:20]};               // LD offset
    assign imm_s = {{52{ir[31]}}, ir[31:25], ir[11:7]};     // SD offset, split field

    // Classify
    always_comb begin
        op = OP_NOP;
        if (ir == MRET_WORD) begin
            op = OP_MRET;
        end else begin
            case (opcode)
                OPC_LUI:   op = OP_LUI;
                OPC_LOAD:  op = (funct3 == F3_DOUBLE) ? OP_LD : OP_NOP;   // LD only
                OPC_STORE: op = (funct3 == F3_DOUBLE) ? OP_SD : OP_NOP;   // SD only
                default:   op = OP_NOP;
            endcase
        end
    end

    // One immediate out, picked by operation
    always_comb begin
        case (op)
            OP_LUI:  imm = imm_u;
            OP_LD:   imm = imm_i;
            OP_SD:   imm = imm_s;
            default: imm = '0;     // MRET and no-op carry none
        endcase
    end

endmodule

`default_nettype wire

/* rv64_execute.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rv64_min_cfg.svh"

module rv64_execute (
    input  logic                   clk,
    input  logic                   reset,
    input  rv64_isa_pkg::op_e      op,
    input  rv64_isa_pkg::reg_idx_t rd,
    input  rv64_isa_pkg::xword_t   imm,
    input  rv64_isa_pkg::xword_t   rs1_data,
    input  rv64_isa_pkg::xword_t   rs2_data,
    input  logic [3:0]             interrupt_vector,  // Request level from outside
    input  rv64_isa_pkg::xword_t   bus_read_data,     // Valid one cycle after read strobe
    output rv64_isa_pkg::xword_t   pc,
    output logic                   interrupt_ack,
    output rv64_isa_pkg::xword_t   bus_address,
    output rv64_isa_pkg::xword_t   bus_write_data,
    output logic                   bus_write_enable,
    output logic                   bus_read_enable,
    output logic                   rd_write,
    output rv64_isa_pkg::reg_idx_t rd_index,
    output rv64_isa_pkg::xword_t   rd_data
);
    import rv64_isa_pkg::*;
    import rv64_csr_pkg::*;

    // Machine CSRs
    xword_t mstatus;
    xword_t mepc;
    xword_t mcause;
    xword_t mtvec;

    logic   bubble;     // Squash the instruction in ir this cycle
    logic   load_step;  // LD is in its second pass
    logic   take_irq;
    logic   active;     // ir really executes
    xword_t mem_addr;

    // CSR reader by address
    function automatic xword_t csr_read(input csr_addr_t addr);
        case (addr)
            CSR_MSTATUS: csr_read = mstatus;
            CSR_MEPC:    csr_read = mepc;
            CSR_MCAUSE:  csr_read = mcause;
            CSR_MTVEC:   csr_read = mtvec;
            default:     csr_read = '0;
        endcase
    endfunction

    assign take_irq = (interrupt_vector == 4'd1) && mstatus[MSTATUS_MIE];
    assign active   = !take_irq && !bubble;
    assign mem_addr = rs1_data + imm;  // imm is I for LD, S for SD

    // Write-back request, same cycle as execute
    assign rd_index = rd;
    assign rd_data  = (op == OP_LD) ? bus_read_data : imm;

    always_comb begin
        rd_write = 1'b0;
        if (active && (rd != '0)) begin            // x0 stays zero
            case (op)
                OP_LUI:  rd_write = 1'b1;
                OP_LD:   rd_write = load_step;     // Data arrives on the second pass
                default: rd_write = 1'b0;
            endcase
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc                   <= `RAM_BASE;
            bubble               <= 1'b0;
            load_step            <= 1'b0;
            interrupt_ack        <= 1'b0;
            bus_read_enable      <= 1'b0;
            bus_write_enable     <= 1'b0;
            bus_address          <= `RAM_BASE;
            bus_write_data       <= '0;
            mstatus              <= '0;
            mstatus[MSTATUS_MIE] <= 1'b1;  // Interrupts on out of reset
            mepc                 <= '0;
            mcause               <= '0;
            mtvec                <= `MTVEC_RESET;
        end else begin
            // Defaults, may be overridden below
            pc               <= pc + 64'd4;
            interrupt_ack    <= 1'b0;
            bus_read_enable  <= 1'b0;
            bus_write_enable <= 1'b0;
            bus_address      <= `RAM_BASE;  // Bus idles at RAM base
            bus_write_data   <= '0;

            if (take_irq) begin
                mepc                  <= pc;  // Resume at the word being fetched
                mcause                <= CAUSE_M_EXT_INT;
                mstatus[MSTATUS_MPIE] <= mstatus[MSTATUS_MIE];
                mstatus[MSTATUS_MIE]  <= 1'b0;
                pc                    <= csr_read(CSR_MTVEC);
                bubble                <= 1'b1;  // Word fetched now is wrong path
                load_step             <= 1'b0;  // Abandoned LD restarts after MRET
                interrupt_ack         <= 1'b1;
            end else if (bubble) begin
                bubble <= 1'b0;
            end else begin
                case (op)
                    OP_MRET: begin
                        pc                    <= csr_read(CSR_MEPC);
                        bubble                <= 1'b1;
                        mstatus[MSTATUS_MIE]  <= mstatus[MSTATUS_MPIE];
                        mstatus[MSTATUS_MPIE] <= 1'b1;
                    end
                    OP_LD: begin
                        if (!load_step) begin
                            bus_address     <= mem_addr;
                            bus_read_enable <= 1'b1;
                            pc              <= pc - 64'd4;  // Refetch this LD
                            bubble          <= 1'b1;        // Skip next slot while bus reads
                            load_step       <= 1'b1;
                        end else begin
                            load_step <= 1'b0;              // Write-back done combinationally
                        end
                    end
                    OP_SD: begin
                        bus_address      <= mem_addr;
                        bus_write_data   <= rs2_data;
                        bus_write_enable <= 1'b1;
                    end
                    default: ;  // LUI writes via rd_write, no-op just advances
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* rv64_isa_pkg.sv */
`default_nettype none

package rv64_isa_pkg;

    // Base word types
    typedef logic [31:0] iword_t;   // Instruction word
    typedef logic [63:0] xword_t;   // XLEN data word
    typedef logic [4:0]  reg_idx_t; // x0..x31

    // Operations the core knows
    typedef enum logic [2:0] {
        OP_NOP  = 3'd0,  // Anything else, pc just advances
        OP_LUI  = 3'd1,
        OP_LD   = 3'd2,
        OP_SD   = 3'd3,
        OP_MRET = 3'd4
    } op_e;

    typedef logic [6:0] opcode_t;
    typedef logic [2:0] funct3_t;

    // Major opcodes
    localparam opcode_t OPC_LUI   = 7'b0110111;
    localparam opcode_t OPC_LOAD  = 7'b0000011;
    localparam opcode_t OPC_STORE = 7'b0100011;

    // Doubleword width in funct3, shared by LD and SD
    localparam funct3_t F3_DOUBLE = 3'b011;

    // MRET is one fixed word
    // funct12 0x302, rs1 0, funct3 0, rd 0, SYSTEM opcode
    localparam iword_t MRET_WORD = 32'h3020_0073;

    // Field positions in the instruction word
    localparam int unsigned RD_LSB  = 7;
    localparam int unsigned F3_LSB  = 12;
    localparam int unsigned RS1_LSB = 15;
    localparam int unsigned RS2_LSB = 20;

endpackage

`default_nettype wire

/* rv64_min.f */
+incdir+.
rv64_isa_pkg.sv
rv64_csr_pkg.sv
rv64_decode.sv
rv64_execute.sv
rv64_result.sv
rv64_core.sv
rv64_min_tb.sv

/* rv64_min_cfg.svh */
`ifndef RV64_MIN_CFG_SVH
`define RV64_MIN_CFG_SVH

// Start of RAM, pc after reset
`define RAM_BASE 64'h0000_0000_8000_0000

// Trap handler entry, sits inside RAM
`define MTVEC_RESET 64'h0000_0000_8000_0200

// Opcode 7'b0000001 is not decoded, so the first execute cycle is a no-op
`define IR_RESET 32'h0000_0001

`endif

/* rv64_min_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rv64_min_cfg.svh"

module rv64_min_tb;
    import rv64_isa_pkg::*;

    localparam int unsigned WAIT_LIMIT = 100;                      // Cycles per wait loop
    localparam xword_t      DATA_BASE  = 64'h0000_0000_0000_1000;  // x5 after its LUI
    localparam int          LD_IDX     = 6;    // Word indices from RAM_BASE
    localparam int          LD_X0_IDX  = 9;
    localparam int          IRQ_IDX    = 13;   // No-op run spans 11..26
    localparam int          MRET_IDX   = 130;  // Handler starts at word 128

    logic       clk;
    logic       reset;
    iword_t     instruction;
    logic [3:0] interrupt_vector;
    xword_t     bus_read_data;
    xword_t     pc;
    logic       heartbeat;
    logic       interrupt_ack;
    xword_t     bus_address;
    xword_t     bus_write_data;
    logic       bus_write_enable;
    logic       bus_read_enable;

    iword_t imem [256];
    xword_t dmem [64];

    // Expected bus traffic, in program order
    xword_t store_addr_q [$];
    xword_t store_data_q [$];
    xword_t read_addr_q  [$];

    int unsigned check_errors   = 0;
    int unsigned timeout_errors = 0;
    int unsigned ack_count      = 0;
    int unsigned ld_pc_count    = 0;
    int unsigned ld_x0_pc_count = 0;
    int unsigned irq_delay;
    int unsigned cycles;
    logic [19:0] imm_a;
    logic [19:0] imm_b;
    logic [19:0] imm_c;
    logic [19:0] imm_d;
    xword_t      loaded_word;  // Preload read back by the LD at word 6
    xword_t      last_pc;
    xword_t      saved_pc;
    logic        hb_expect;    // Heartbeat level due on this falling edge

    rv64_core UUT (
        .clk              (clk),
        .reset            (reset),
        .instruction      (instruction),
        .interrupt_vector (interrupt_vector),
        .bus_read_data    (bus_read_data),
        .pc               (pc),
        .heartbeat        (heartbeat),
        .interrupt_ack    (interrupt_ack),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_write_enable (bus_write_enable),
        .bus_read_enable  (bus_read_enable)
    );

    assign instruction = imem[pc[9:2]];  // Base has zero low bits

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ADDI x0, x0, idx: a no-op tagged with its own word index
    function automatic iword_t noop_at(input int idx);
        return {12'(idx), 5'd0, 3'b000, 5'd0, 7'b0010011};
    endfunction

    function automatic iword_t lui_insn(input reg_idx_t rd, input logic [19:0] imm20);
        return {imm20, rd, 7'b0110111};
    endfunction

    function automatic iword_t ld_insn(input reg_idx_t rd, input reg_idx_t rs1,
                                       input logic [11:0] offset);
        return {offset, rs1, 3'b011, rd, 7'b0000011};
    endfunction

    function automatic iword_t sd_insn(input reg_idx_t rs2, input reg_idx_t rs1,
                                       input logic [11:0] offset);
        return {offset[11:5], rs2, rs1, 3'b011, offset[4:0], 7'b0100011};
    endfunction

    // U immediate into bits 31:12, then 32-bit signed value widened to 64
    function automatic xword_t lui_result(input logic [19:0] imm20);
        int upper;
        upper = {imm20, 12'h000};
        return 64'(upper);
    endfunction

    function automatic xword_t pc_of(input int idx);
        return `RAM_BASE + 64'(idx) * 64'd4;
    endfunction

    task automatic check(input bit ok, input string what);
        assert (ok) else begin
            check_errors++;
            $display("Fail at %0t: %s", $time, what);
        end
    endtask

    task automatic queue_store(input xword_t addr, input xword_t data);
        store_addr_q.push_back(addr);
        store_data_q.push_back(data);
    endtask

    task automatic wait_for_pc(input xword_t target, input string what);
        int unsigned count;
        count = 0;
        do begin
            @(negedge clk);
            count++;
        end while (pc !== target && count < WAIT_LIMIT);
        if (pc !== target) begin
            timeout_errors++;
            $display("Timeout at %0t: pc never reached %s", $time, what);
        end
    endtask

    // Data memory, answers the cycle after the read strobe
    always @(posedge clk) begin
        if (bus_read_enable === 1'b1) begin
            bus_read_data <= dmem[bus_address[8:3]];
        end
        if (bus_write_enable === 1'b1) begin
            dmem[bus_address[8:3]] <= bus_write_data;
        end
    end

    // Bus, interrupt and heartbeat monitor, mid-cycle where outputs are settled
    always @(negedge clk) begin : bus_monitor
        xword_t exp_addr;
        xword_t exp_data;
        if (reset === 1'b1) begin
            check(heartbeat === hb_expect,
                  $sformatf("heartbeat %b, expected %b", heartbeat, hb_expect));
            hb_expect = ~hb_expect;  // Flips every cycle
            if (interrupt_ack === 1'b1) ack_count++;
            if (pc == pc_of(LD_IDX)) ld_pc_count++;        // Fetch plus refetch
            if (pc == pc_of(LD_X0_IDX)) ld_x0_pc_count++;
            if (bus_read_enable === 1'b1) begin
                if (read_addr_q.size() == 0) begin
                    check(1'b0, $sformatf("extra bus read at %h", bus_address));
                end else begin
                    exp_addr = read_addr_q.pop_front();
                    check(bus_address == exp_addr,
                          $sformatf("read at %h, expected %h", bus_address, exp_addr));
                end
            end
            if (bus_write_enable === 1'b1) begin
                if (store_addr_q.size() == 0) begin
                    check(1'b0, $sformatf("extra bus write at %h", bus_address));
                end else begin
                    exp_addr = store_addr_q.pop_front();
                    exp_data = store_data_q.pop_front();
                    check(bus_address == exp_addr && bus_write_data == exp_data,
                          $sformatf("store %h to %h, expected %h to %h",
                                    bus_write_data, bus_address, exp_data, exp_addr));
                end
            end
        end else begin
            hb_expect = 1'b0;  // Toggle restarts from its reset level
        end
    end

    initial begin
        reset            <= 1'b0;
        interrupt_vector <= 4'd0;
        bus_read_data    <= '0;
        void'($urandom(32'hb583e97a));
        imm_a       = 20'($urandom);
        imm_b       = 20'($urandom);
        imm_c       = 20'($urandom) | 20'h1;  // Nonzero, so the x0 write would show
        imm_d       = 20'($urandom);
        loaded_word = {$urandom, $urandom};
        irq_delay   = $urandom_range(7, 0);
        last_pc     = '0;

        for (int i = 0; i < 256; i++) begin
            imem[i] = noop_at(i);
        end
        for (int i = 0; i < 64; i++) begin
            dmem[i] <= {$urandom, $urandom};
        end
        dmem[1] <= loaded_word;

        imem[1]  = lui_insn(5'd5, 20'h00001);        // x5 = DATA_BASE
        imem[2]  = lui_insn(5'd6, imm_a);
        imem[3]  = sd_insn(5'd6, 5'd5, 12'h018);
        imem[4]  = lui_insn(5'd7, imm_b);
        imem[5]  = sd_insn(5'd7, 5'd5, 12'hff8);     // Negative S offset
        imem[6]  = ld_insn(5'd8, 5'd5, 12'h008);
        imem[7]  = sd_insn(5'd8, 5'd5, 12'h028);
        imem[8]  = lui_insn(5'd0, imm_c);
        imem[9]  = ld_insn(5'd0, 5'd5, 12'h010);
        imem[10] = sd_insn(5'd0, 5'd5, 12'h030);     // x0 must still read zero
        imem[27] = lui_insn(5'd9, imm_d);            // First work after MRET
        imem[28] = sd_insn(5'd9, 5'd5, 12'h038);
        imem[MRET_IDX] = 32'h3020_0073;

        queue_store(DATA_BASE + 64'h18, lui_result(imm_a));
        queue_store(DATA_BASE - 64'h8, lui_result(imm_b));
        queue_store(DATA_BASE + 64'h28, loaded_word);
        queue_store(DATA_BASE + 64'h30, 64'd0);
        queue_store(DATA_BASE + 64'h38, lui_result(imm_d));
        read_addr_q.push_back(DATA_BASE + 64'h8);
        read_addr_q.push_back(DATA_BASE + 64'h10);

        repeat (9) @(posedge clk);
        @(negedge clk);
        check(pc == `RAM_BASE && !bus_read_enable && !bus_write_enable && !interrupt_ack
              && !heartbeat,
              "outputs not at their reset values");
        @(posedge clk);
        reset <= 1'b1;

        // Straight-line fetch, 4 bytes per cycle
        @(negedge clk);
        check(pc == `RAM_BASE, $sformatf("pc %h after reset release", pc));
        for (int i = 1; i <= 5; i++) begin
            @(negedge clk);
            check(pc == pc_of(i), $sformatf("pc %h, expected %h", pc, pc_of(i)));
        end

        // Interrupt lands while no-ops are fetched and executed
        wait_for_pc(pc_of(IRQ_IDX), "the no-op run");
        repeat (irq_delay) @(posedge clk);
        @(posedge clk);
        interrupt_vector <= 4'd1;  // Held through the handler
        cycles = 0;
        @(negedge clk);
        while (interrupt_ack !== 1'b1 && cycles < WAIT_LIMIT) begin
            last_pc = pc;
            @(negedge clk);
            cycles++;
        end
        if (interrupt_ack !== 1'b1) begin
            timeout_errors++;
            $display("Timeout at %0t: no interrupt_ack after the request", $time);
        end
        saved_pc = pc_of(IRQ_IDX + 1 + irq_delay);  // Word fetched when the request is taken
        check(pc == `MTVEC_RESET, $sformatf("pc %h on interrupt_ack", pc));
        check(last_pc == saved_pc,
              $sformatf("interrupted at pc %h, expected %h", last_pc, saved_pc));

        // MIE clear in the handler, so the held level is ignored
        wait_for_pc(pc_of(MRET_IDX), "MRET in the handler");
        check(ack_count == 1, $sformatf("%0d interrupt_ack pulses before MRET", ack_count));
        @(posedge clk);
        interrupt_vector <= 4'd0;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while ((pc == pc_of(MRET_IDX) || pc == pc_of(MRET_IDX + 1)) && cycles < WAIT_LIMIT);
        check(pc == saved_pc, $sformatf("pc %h after MRET, expected %h", pc, saved_pc));

        cycles = 0;
        while (store_addr_q.size() != 0 && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (store_addr_q.size() != 0) begin
            timeout_errors++;
            $display("Timeout at %0t: %0d stores never seen", $time, store_addr_q.size());
        end
        repeat (4) @(negedge clk);  // Room for stray strobes

        check(read_addr_q.size() == 0, "fewer bus reads than LD instructions");
        check(ack_count == 1, $sformatf("%0d interrupt_ack pulses in total", ack_count));
        check(ld_pc_count == 2, $sformatf("LD address on pc %0d times", ld_pc_count));
        check(ld_x0_pc_count == 2, $sformatf("LD x0 address on pc %0d times", ld_x0_pc_count));

        $display("Check errors: %0d, timeouts: %0d", check_errors, timeout_errors);
        if (check_errors == 0 && timeout_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rv64_result.sv */
`timescale 1ns/100ps
`default_nettype none

module rv64_result (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   rd_write,  // Write-back strobe
    input  rv64_isa_pkg::reg_idx_t rd_index,
    input  rv64_isa_pkg::xword_t   rd_data,
    input  rv64_isa_pkg::reg_idx_t rs1,
    input  rv64_isa_pkg::reg_idx_t rs2,
    output rv64_isa_pkg::xword_t   rs1_data,
    output rv64_isa_pkg::xword_t   rs2_data
);
    import rv64_isa_pkg::*;

    localparam int unsigned REG_COUNT = 32;

    xword_t regs [REG_COUNT];  // x0..x31

    // Commit at the edge
    // Execute never strobes x0, so it keeps its reset zero
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_write) begin
            regs[rd_index] <= rd_data;
        end
    end

    // Two async read ports
    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];  // SD data source

endmodule

`default_nettype wire
